// File: common/stm_pkg.sv
// Gain memory geometry and read address layout shared by the STM gain pipeline blocks.
package stm_pkg;

  // one memory word packs eight 16-bit transducer slots.
  // phase sits in the low byte of a slot, raw duty in the high byte.
  localparam int gain_word_bits = 128;

  localparam int gain_slot_bits = 16;

  localparam int gain_lanes = 8;

  // the operator's read address is {base, offset}.
  // base selects a block of 64 words holding two frames.
  localparam int gain_addr_bits = 16;

  localparam int gain_base_bits = 10;

  localparam int gain_offset_bits = 6;

  // odd frames start halfway into their base block.
  localparam int odd_frame_offset = 32;

endpackage

// File: logic/duty_modulator.sv
// Duty modulator: scales each streamed duty by an 8-bit level and keeps phase and valid aligned.
`timescale 1ns/100ps

module duty_modulator #(
  parameter int WIDTH = 9
) (
  input  logic             CLK,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] duty,
  input  logic [WIDTH-1:0] phase,
  input  logic             dout_valid,
  input  logic [7:0]       mod_level,
  output logic [WIDTH-1:0] duty_out,
  output logic [WIDTH-1:0] phase_out,
  output logic             valid_out
);

  localparam int prod_bits = WIDTH + 8;

  logic [prod_bits-1:0] product;
  logic [prod_bits-1:0] scaled;

  // full scale is 255, so a level of 255 leaves duty as it is.
  assign product = duty * mod_level;
  assign scaled  = product / prod_bits'(255);

  always_ff @(posedge CLK) begin
    duty_out  <= scaled[WIDTH-1:0];
    phase_out <= phase;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= dout_valid;
    end
  end

endmodule

// File: logic/stm_gain_top.sv
// STM gain pipeline top: timer, gain RAM, gain operator and duty modulator in four stages.
`timescale 1ns/100ps

module stm_gain_top #(
  parameter int WIDTH = 9,
  parameter int DEPTH = 249,
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic                               CLK,
  input  logic                               rst_n,
  input  logic                               wr_en,
  input  logic [15:0]                        wr_addr,
  input  logic [stm_pkg::gain_slot_bits-1:0] wr_data,
  input  logic                               stm_en,
  input  logic [15:0]                        freq_div,
  input  logic [15:0]                        cycle,
  input  logic [7:0]                         mod_level,
  output logic [WIDTH-1:0]                   duty_out,
  output logic [WIDTH-1:0]                   phase_out,
  output logic                               valid_out
);

  import stm_pkg::*;

  logic                      update;
  logic [15:0]               idx;
  logic [gain_addr_bits-1:0] gain_addr;
  logic [gain_word_bits-1:0] gain_data;
  logic [WIDTH-1:0]          duty;
  logic [WIDTH-1:0]          phase;
  logic                      dout_valid;

  stm_timer stm_timer_inst (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .stm_en   (stm_en),
    .freq_div (freq_div),
    .cycle    (cycle),
    .update   (update),
    .idx      (idx)
  );

  gain_memory #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) gain_memory_inst (
    .CLK     (CLK),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (gain_addr),
    .rd_data (gain_data)
  );

  // update to first dout_valid is three cycles, the modulator adds one more.
  stm_gain_operator #(
    .WIDTH (WIDTH),
    .DEPTH (DEPTH)
  ) stm_gain_operator_inst (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .update     (update),
    .idx        (idx),
    .gain_addr  (gain_addr),
    .gain_data  (gain_data),
    .duty       (duty),
    .phase      (phase),
    .dout_valid (dout_valid)
  );

  duty_modulator #(
    .WIDTH (WIDTH)
  ) duty_modulator_inst (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .duty       (duty),
    .phase      (phase),
    .dout_valid (dout_valid),
    .mod_level  (mod_level),
    .duty_out   (duty_out),
    .phase_out  (phase_out),
    .valid_out  (valid_out)
  );

endmodule

// File: logic/stm_timer.sv
// STM sampling timer: issues one update strobe and a wrapping frame index every freq_div cycles.
`timescale 1ns/100ps

module stm_timer (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        stm_en,
  input  logic [15:0] freq_div,
  input  logic [15:0] cycle,
  output logic        update,
  output logic [15:0] idx
);

  logic [15:0] period_cnt;
  logic [15:0] frame;
  logic        period_end;
  logic        frame_last;

  // a freq_div of one fires every cycle.
  assign period_end = (period_cnt >= freq_div - 16'd1);
  assign frame_last = (frame >= cycle - 16'd1);

  // frame holds the index for the next strobe, so the first strobe carries 0.
  always_ff @(posedge CLK) begin
    if (!rst_n || !stm_en) begin
      period_cnt <= '0;
      frame      <= '0;
      update     <= 1'b0;
      idx        <= '0;
    end else begin
      update <= (period_cnt == '0);
      if (period_cnt == '0) begin
        idx   <= frame;
        frame <= frame_last ? '0 : frame + 16'd1;
      end
      period_cnt <= period_end ? '0 : period_cnt + 16'd1;
    end
  end

  // once STM is switched off, no further strobe may follow.
  a_no_update_when_disabled: assert property (
    @(posedge CLK) disable iff (!rst_n)
    !stm_en |=> !update
  ) else $error("update pulsed after stm_en went low");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the STM gain testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_stm_gain -f vlog.f \
  && ./obj_dir/Vtb_stm_gain > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// File: stm/gain_memory.sv
// Gain RAM: the host writes one 16-bit slot per cycle and the operator reads whole 128-bit words.
`timescale 1ns/100ps

module gain_memory #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic                               CLK,
  input  logic                               wr_en,
  input  logic [15:0]                        wr_addr,
  input  logic [stm_pkg::gain_slot_bits-1:0] wr_data,
  input  logic [stm_pkg::gain_addr_bits-1:0] rd_addr,
  output logic [stm_pkg::gain_word_bits-1:0] rd_data
);

  import stm_pkg::*;

  localparam int lane_bits = $clog2(gain_lanes);
  localparam int words = 1 << MEM_ADDR_BITS;

  logic [gain_word_bits-1:0]                  mem [words];
  logic [lane_bits-1:0]                       wr_lane;
  logic [15-lane_bits:0]                      wr_word;
  logic [gain_base_bits-1:0]                  rd_base;
  logic [gain_offset_bits-1:0]                rd_offset;
  logic [gain_base_bits+gain_offset_bits-1:0] rd_word;
  logic [MEM_ADDR_BITS-1:0]                   rd_addr_q;

  // host address: word number above, slot lane in the low bits.
  assign wr_lane = wr_addr[lane_bits-1:0];
  assign wr_word = wr_addr[15:lane_bits];

  // each base block spans 2**gain_offset_bits words.
  assign rd_base   = rd_addr[gain_addr_bits-1 -: gain_base_bits];
  assign rd_offset = rd_addr[gain_offset_bits-1:0];
  assign rd_word   = {rd_base, rd_offset};

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_word[MEM_ADDR_BITS-1:0]][wr_lane*gain_slot_bits +: gain_slot_bits] <= wr_data;
    end
  end

  // two-stage read: address register, then data register.
  always_ff @(posedge CLK) begin
    rd_addr_q <= rd_word[MEM_ADDR_BITS-1:0];
    rd_data   <= mem[rd_addr_q];
  end

  // upper word bits are not decoded, so an out-of-range write would alias.
  a_write_in_range: assert property (
    @(posedge CLK)
    wr_en |-> ((wr_word >> MEM_ADDR_BITS) == '0)
  ) else $error("gain write beyond memory size, word %0d", wr_word);

endmodule

// File: stm/stm_gain_operator.sv
// Gain operator: on each update reads one frame from the gain RAM and streams duty and phase.
`timescale 1ns/100ps

module stm_gain_operator #(
  parameter int WIDTH = 9,
  parameter int DEPTH = 249
) (
  input  logic                               CLK,
  input  logic                               rst_n,
  input  logic                               update,
  input  logic [15:0]                        idx,
  output logic [stm_pkg::gain_addr_bits-1:0] gain_addr,
  input  logic [stm_pkg::gain_word_bits-1:0] gain_data,
  output logic [WIDTH-1:0]                   duty,
  output logic [WIDTH-1:0]                   phase,
  output logic                               dout_valid
);

  import stm_pkg::*;

  localparam int lane_bits = $clog2(gain_lanes);
  localparam int cnt_bits = $clog2(DEPTH + 1);

  // the next word must be requested three lanes early.
  // two cycles cover the RAM and one covers the offset register.
  localparam int advance_lane = gain_lanes - 3;

  typedef enum logic [1:0] {
    waiting,
    bram_wait_0,
    bram_wait_1,
    run
  } gain_state_t;

  gain_state_t state;

  logic [gain_base_bits-1:0]   addr_base;
  logic [gain_offset_bits-1:0] addr_offset;
  logic [lane_bits-1:0]        lane;
  logic [cnt_bits-1:0]         cnt;
  logic [gain_slot_bits-1:0]   slot;
  logic [7:0]                  raw_duty;
  logic [7:0]                  raw_phase;

  assign gain_addr = {addr_base, addr_offset};

  assign slot      = gain_data[lane*gain_slot_bits +: gain_slot_bits];
  assign raw_phase = slot[7:0];
  assign raw_duty  = slot[gain_slot_bits-1 -: 8];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state      <= waiting;
      dout_valid <= 1'b0;
      lane       <= '0;
      cnt        <= '0;
    end else begin
      case (state)
        waiting: begin
          dout_valid <= 1'b0;
          if (update) begin
            // two frames share one base block.
            addr_base   <= idx[gain_base_bits:1];
            addr_offset <= idx[0] ? gain_offset_bits'(odd_frame_offset) : '0;
            state       <= bram_wait_0;
          end
        end
        bram_wait_0: begin
          state <= bram_wait_1;
        end
        bram_wait_1: begin
          cnt   <= '0;
          lane  <= '0;
          state <= run;
        end
        run: begin
          dout_valid <= 1'b1;
          // a raw duty of zero stays off, anything else is lifted by one.
          duty  <= (raw_duty == 8'h00) ? '0 : WIDTH'(raw_duty) + WIDTH'(1);
          phase <= WIDTH'({raw_phase, 1'b0});
          lane  <= lane + lane_bits'(1);
          if (lane == lane_bits'(advance_lane)) begin
            addr_offset <= addr_offset + gain_offset_bits'(1);
          end
          cnt <= cnt + cnt_bits'(1);
          if (cnt == cnt_bits'(DEPTH - 1)) begin
            state <= waiting;
          end
        end
        default: begin
          state <= waiting;
        end
      endcase
    end
  end

  // the stream must be quiet while the RAM is being primed.
  a_quiet_while_priming: assert property (
    @(posedge CLK) disable iff (!rst_n)
    (state == bram_wait_0 || state == bram_wait_1) |-> !dout_valid
  ) else $error("dout_valid high during RAM wait states");

endmodule

// File: testbench/tb_utils.svh
// Testbench helpers for the STM gain testbench: LFSR stimulus, value check and error counters.
`ifndef TB_UTILS_SVH
`define TB_UTILS_SVH

int unsigned error_count = 0;
int unsigned check_count = 0;
logic [31:0] lfsr_state = 32'hb7e1;

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
endfunction

// takes n bits from the LFSR, one step per bit.
function automatic logic [31:0] random_bits(input int n);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < n; i++) begin
    value = {value[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return value;
endfunction

task automatic check_value(input string test_name, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("ERR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
  end
endtask

task automatic report_problem(input string text);
  error_count++;
  $display("%s", text);
endtask

`endif

// File: testbench/tb_stm_gain.sv
// Directed testbench for the STM gain pipeline that loads gain slots, runs STM and checks bursts.
`timescale 1ns/100ps

module tb_stm_gain;

  localparam int WIDTH = 9;
  localparam int DEPTH = 249;
  localparam int WAIT_LIMIT = 1000;

  logic             CLK;
  logic             rst_n;
  logic             wr_en;
  logic [15:0]      wr_addr;
  logic [15:0]      wr_data;
  logic             stm_en;
  logic [15:0]      freq_div;
  logic [15:0]      cycle;
  logic [7:0]       mod_level;
  logic [WIDTH-1:0] duty_out;
  logic [WIDTH-1:0] phase_out;
  logic             valid_out;

  // host view of every written slot indexed like wr_addr.
  logic [15:0] slot_model [0:8191];

  `include "tb_utils.svh"

  stm_gain_top stm_gain_top_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // two frames share a 64-word base block and odd frames start at word 32.
  function automatic int slot_addr(input int f, input int j);
    int word;
    word = (f / 2) * 64 + ((f % 2) ? 32 : 0) + j / 8;
    return word * 8 + j % 8;
  endfunction

  task automatic write_slot(input int addr, input logic [15:0] data);
    @(posedge CLK);
    wr_en   <= 1'b1;
    wr_addr <= addr[15:0];
    wr_data <= data;
    slot_model[addr] = data;
  endtask

  // raw duty alternates between 0 and 255 when edges is set.
  task automatic load_frames(input int frames, input bit edges);
    logic [15:0] data;
    for (int f = 0; f < frames; f++) begin
      for (int j = 0; j < DEPTH; j++) begin
        data = 16'(random_bits(edges ? 8 : 16));
        if (edges) begin
          data[15:8] = (j % 2) ? 8'hff : 8'h00;
        end
        write_slot(slot_addr(f, j), data);
      end
    end
    @(posedge CLK);
    wr_en <= 1'b0;
  endtask

  task automatic start_stm(input logic [15:0] div, input logic [15:0] frames,
                           input logic [7:0] level);
    @(posedge CLK);
    freq_div  <= div;
    cycle     <= frames;
    mod_level <= level;
    stm_en    <= 1'b1;
  endtask

  task automatic stop_stm(input string test_name);
    int quiet;
    quiet = 0;
    @(posedge CLK);
    stm_en <= 1'b0;
    for (int n = 0; n < WAIT_LIMIT && quiet < 8; n++) begin
      @(negedge CLK);
      quiet = valid_out ? 0 : quiet + 1;
    end
    if (quiet < 8) begin
      report_problem($sformatf("%s: valid_out did not settle after STM was disabled", test_name));
    end
  endtask

  task automatic wait_valid(input string test_name, output bit found);
    found = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !found; n++) begin
      @(negedge CLK);
      found = valid_out;
    end
    if (!found) begin
      report_problem($sformatf("%s: timed out waiting for valid_out", test_name));
    end
  endtask

  task automatic check_burst(input string test_name, input int frame, input int level);
    bit          found;
    logic [15:0] slot;
    int          duty;
    wait_valid(test_name, found);
    if (found) begin
      for (int j = 0; j < DEPTH; j++) begin
        if (j > 0) begin
          @(negedge CLK);
        end
        slot = slot_model[slot_addr(frame, j)];
        duty = (slot[15:8] == 8'h00) ? 0 : int'(slot[15:8]) + 1;
        check_value(test_name, "valid", 1, valid_out);
        check_value(test_name, "duty", duty * level / 255, duty_out);
        check_value(test_name, "phase", {slot[7:0], 1'b0}, phase_out);
        check_value(test_name, "phase lsb", 0, phase_out[0]);
      end
      @(negedge CLK);
      check_value(test_name, "valid after burst", 0, valid_out);
    end
  endtask

  task automatic reset_idle();
    for (int n = 0; n < 50; n++) begin
      @(negedge CLK);
      check_value("reset_idle", "valid", 0, valid_out);
    end
  endtask

  task automatic frame_even();
    load_frames(4, 1'b0);
    start_stm(16'd300, 16'd4, 8'd255);
    check_burst("frame_even", 0, 255);
  endtask

  // frame 1 sits at offset 32 of base 0, frames 2 and 3 use base 1.
  task automatic frame_odd();
    for (int f = 1; f < 4; f++) begin
      check_burst("frame_odd", f, 255);
    end
  endtask

  task automatic duty_edges();
    stop_stm("duty_edges");
    load_frames(1, 1'b1);
    start_stm(16'd300, 16'd1, 8'd255);
    check_burst("duty_edges", 0, 255);
  endtask

  task automatic modulation();
    stop_stm("modulation");
    load_frames(1, 1'b0);
    start_stm(16'd300, 16'd1, 8'd128);
    check_burst("modulation", 0, 128);
  endtask

  task automatic index_wrap();
    bit found;
    bit on;
    int high;
    stop_stm("index_wrap");
    start_stm(16'd300, 16'd2, 8'd255);
    check_burst("index_wrap", 0, 255);
    check_burst("index_wrap", 1, 255);
    check_burst("index_wrap", 0, 255);
    // STM drops during the fourth burst and that burst must still run to its end.
    wait_valid("index_wrap", found);
    @(posedge CLK);
    stm_en <= 1'b0;
    on = found;
    high = found ? 1 : 0;
    for (int n = 0; n < WAIT_LIMIT && on; n++) begin
      @(negedge CLK);
      on = valid_out;
      if (on) begin
        high++;
      end
    end
    check_value("index_wrap", "burst length after stop", DEPTH, high);
    for (int n = 0; n < 600; n++) begin
      @(negedge CLK);
      if (valid_out) begin
        report_problem("index_wrap: valid_out went high after STM was disabled");
        break;
      end
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    stm_en    = 1'b0;
    freq_div  = 16'd300;
    cycle     = 16'd4;
    mod_level = 8'd255;
    repeat (10) @(posedge CLK);
    rst_n <= 1'b1;
    reset_idle();
    frame_even();
    frame_odd();
    duty_edges();
    modulation();
    index_wrap();
    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+testbench
common/stm_pkg.sv
logic/stm_timer.sv
stm/gain_memory.sv
stm/stm_gain_operator.sv
logic/duty_modulator.sv
logic/stm_gain_top.sv
testbench/tb_stm_gain.sv
